// File: test/rpnCalcPatterns.txt
// act_data_f_display_s_fl  act 0 none, 1 enter, 2 undo, 3 bounce only, F end
// f 1 decimal, display digit 7..0, s Status, fl negative zero carry overflow
0_1234_0_00001234_0_0
0_FFFF_1_00065535_0_0
3_FFFF_0_0000FFFF_0_0
1_FFFF_0_0000FFFF_1_0
1_005A_0_0000005A_2_0
0_0001_0_00000001_2_0
1_0001_0_0000FFA5_3_8
0_0001_1_00065445_3_8
0_0001_0_0000FFA5_3_8
2_0003_0_00000003_2_0
2_0003_0_00000003_1_0
2_0003_0_00000003_0_0
2_0003_0_00000003_0_0
3_0003_0_00000003_0_0
1_8000_0_00008000_1_0
1_8000_0_00008000_2_0
1_0000_0_00000000_3_7
1_F000_0_0000F000_0_0
1_F000_0_0000F000_1_0
1_3000_0_00003000_2_0
1_0000_0_00002000_3_2
0_0000_1_00008192_3_2
2_0002_0_00000002_2_0
1_0002_0_00003000_3_0
2_0003_0_00000003_2_0
1_0003_0_0000F000_3_8
0_0003_1_00061440_3_8
0_0003_0_0000F000_3_8
F_0000_0_00000000_0_0

// File: flist.f
+incdir+logic
logic/rpnCalcPkg.sv
logic/buttonDebouncer.sv
logic/calcSequencer.sv
logic/rpnAlu.sv
logic/binToBcd.sv
logic/displayScanner.sv
logic/rpnCalcTop.sv
test/rpnCalcTb.sv

// File: Bender.yml
package:
  name: rpn_calc

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/rpnCalcPkg.sv
      - logic/buttonDebouncer.sv
      - logic/calcSequencer.sv
      - logic/rpnAlu.sv
      - logic/binToBcd.sv
      - logic/displayScanner.sv
      - logic/rpnCalcTop.sv
  - target: test
    include_dirs:
      - logic
    files:
      - test/rpnCalcTb.sv

// File: test/rpnCalcTb.sv
`default_nettype none

`include "rpnCalc_cfg.svh"

module rpnCalcTb;

	timeunit 1ns;
	timeprecision 1ps;

	import rpnCalcPkg::*;

	localparam int DebCycles   = `RPN_DEBOUNCE_CYCLES;
	localparam int FrameCycles = 8 * `RPN_SCAN_CYCLES;  // One full scan of eight digits
	localparam int FrameLimit  = 20;                     // Frames polled per display check
	localparam int StatusLimit = 4 * DebCycles + 32;

	logic                       clk;
	logic                       arstN;
	logic                       enter;
	logic                       undo;
	logic                       displayFormat;  // 1 is decimal
	logic [`RPN_DATA_WIDTH-1:0] dataIn;
	logic [6:0]                 segments;
	logic [7:0]                 anodes;
	aluFlags_t                  flags;
	calcState_e                 status;

	logic [63:0] patterns [0:63];  // act, data, format, display, status, flags
	logic [15:0] lfsr;

	rpnCalcTop dut0 (
		.clk           (clk),
		.arstN         (arstN),
		.Enter         (enter),
		.Undo          (undo),
		.DisplayFormat (displayFormat),
		.DataIn        (dataIn),
		.Segments      (segments),
		.Anodes        (anodes),
		.Flags         (flags),
		.Status        (status)
	);

	always #4 clk = ~clk;  // 8 ns period

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	// Fibonacci taps x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic randomBits(input int n, output int v);
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsrNext(lfsr);  // One step per bit
			v    = (v << 1) | int'(lfsr[0]);
		end
	endtask

	// Seven-segment glyph back to its digit, a in bit 0
	function automatic logic [3:0] segToDigit(input logic [6:0] seg);
		logic [6:0] lit;
		lit = ~seg;  // Segments are active low
		case (lit)
			7'h3F: return 4'h0;
			7'h06: return 4'h1;
			7'h5B: return 4'h2;
			7'h4F: return 4'h3;
			7'h66: return 4'h4;
			7'h6D: return 4'h5;
			7'h7D: return 4'h6;
			7'h07: return 4'h7;
			7'h7F: return 4'h8;
			7'h6F: return 4'h9;
			7'h77: return 4'hA;
			7'h7C: return 4'hB;
			7'h39: return 4'hC;
			7'h5E: return 4'hD;
			7'h79: return 4'hE;
			7'h71: return 4'hF;
			default: return 4'hx;  // Not a glyph
		endcase
	endfunction

	// Lit digit, or -1 when not exactly one anode is low
	function automatic int anodeIndex(input logic [7:0] an);
		int idx;
		idx = -1;
		for (int i = 0; i < 8; i++) begin
			if (an === ~(8'b1 << i))
				idx = i;
		end
		return idx;
	endfunction

	task automatic failRun(input string why);
		$display("%s", why);
		$display("Finished with errors");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected)
			failRun($sformatf("Error at %0t ns: %s is %h, expected %h",
				$time, what, actual, expected));
	endtask

	task automatic driveButton(input bit isUndo, input logic level);
		if (isUndo)
			undo = level;
		else
			enter = level;
	endtask

	// Bounce burst, then an optional clean hold, then time for the release to settle
	task automatic pressButton(input bit isUndo, input bit holdIt);
		int glitches;
		int len;
		int gap;
		randomBits(2, glitches);
		for (int g = 0; g <= glitches; g++) begin
			randomBits($clog2(DebCycles), len);
			len = len % (DebCycles - 1) + 1;  // Always shorter than the debounce length
			randomBits(2, gap);
			driveButton(isUndo, 1'b1);
			repeat (len) @(negedge clk);
			driveButton(isUndo, 1'b0);
			repeat (gap + 1) @(negedge clk);
		end
		if (holdIt) begin
			driveButton(isUndo, 1'b1);
			repeat (DebCycles + 8) @(negedge clk);
			driveButton(isUndo, 1'b0);
		end
		repeat (DebCycles + 8) @(negedge clk);
	endtask

	////////////////////////////////////////////////////////////
	// Display decoding and response waits
	////////////////////////////////////////////////////////////

	// One frame from digit 0 through digit 7, digit 7 in the top nibble
	task automatic captureFrame(output logic [31:0] frame);
		logic [7:0] prevAn;
		logic [7:0] seen;
		bit         started;
		int         idx;
		int         cycles;
		prevAn  = anodes;
		seen    = '0;
		started = 0;
		frame   = 'x;
		cycles  = 0;
		while (seen != 8'hFF) begin
			@(negedge clk);
			cycles++;
			if (cycles > 3 * FrameCycles) begin
				failRun("Timeout: the display did not complete a scan frame");
			end else begin
				idx = anodeIndex(anodes);
				if (idx == 0 && prevAn !== 8'hFE)
					started = 1;  // Fresh frame begins
				if (started && idx >= 0) begin
					frame[idx*4 +: 4] = segToDigit(segments);
					seen[idx]         = 1'b1;
				end
				prevAn = anodes;
			end
		end
	endtask

	task automatic waitDisplay(input logic [31:0] expected);
		logic [31:0] frame;
		int          frames;
		frames = 1;
		captureFrame(frame);
		while (frame !== expected && frames < FrameLimit) begin
			captureFrame(frame);
			frames++;
		end
		if (frame !== expected)
			failRun($sformatf("Timeout: display shows %h after %0d frames, expected %h",
				frame, frames, expected));
	endtask

	task automatic waitStatus(input logic [3:0] expState, input logic [3:0] expFlags);
		int cycles;
		cycles = 0;
		while ((status !== expState[1:0] || flags !== expFlags) && cycles < StatusLimit) begin
			@(negedge clk);
			cycles++;
		end
		checkValue(32'(status), 32'(expState), "Status");
		checkValue(32'(flags), 32'(expFlags), "Flags");
	endtask

	////////////////////////////////////////////////////////////
	// Pattern loop
	////////////////////////////////////////////////////////////

	initial begin
		logic [63:0] pat;
		int          count;
		clk           = 1'b0;
		arstN         = 1'b0;
		enter         = 1'b0;
		undo          = 1'b0;
		displayFormat = 1'b0;
		dataIn        = '0;
		lfsr          = 16'd22793;
		count         = 0;
		for (int i = 0; i < 64; i++)
			patterns[i] = '1;  // Reads as the end marker
		$readmemh("test/rpnCalcPatterns.txt", patterns);

		repeat (10) @(negedge clk);
		arstN = 1'b1;

		while (count < 64 && patterns[count][63:60] != 4'hF) begin
			pat = patterns[count];
			@(negedge clk);
			dataIn        = pat[59:44];
			displayFormat = pat[40];
			case (pat[63:60])
				4'h1: pressButton(1'b0, 1'b1);  // Enter
				4'h2: pressButton(1'b1, 1'b1);  // Undo
				4'h3: pressButton(1'b0, 1'b0);  // Bounce only
				default: ;
			endcase
			waitStatus(pat[7:4], pat[3:0]);
			waitDisplay(pat[39:8]);
			count++;
		end

		if (count == 0) begin
			failRun("No patterns were loaded from test/rpnCalcPatterns.txt");
		end else begin
			$display("Finished with no errors");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: logic/rpnCalcTop.sv
`default_nettype none

`include "rpnCalc_cfg.svh"

module rpnCalcTop (
	input  logic                       clk,
	input  logic                       arstN,
	input  logic                       Enter,
	input  logic                       Undo,
	input  logic                       DisplayFormat,  // 1 selects decimal
	input  logic [`RPN_DATA_WIDTH-1:0] DataIn,
	output logic [6:0]                 Segments,
	output logic [7:0]                 Anodes,
	output rpnCalcPkg::aluFlags_t      Flags,
	output rpnCalcPkg::calcState_e     Status
);

	import rpnCalcPkg::*;

	logic                       enterPress;
	logic                       undoPress;
	aluReq_t                    aluReq;
	aluRes_t                    aluRes;
	logic [`RPN_DATA_WIDTH-1:0] dispValue;
	logic                       convValid;
	logic                       convReady;
	logic [`RPN_DATA_WIDTH-1:0] convValue;
	logic                       bcdValid;
	bcdWord_t                   bcd;

	////////////////////////////////////////////////////////////
	// Buttons
	////////////////////////////////////////////////////////////

	buttonDebouncer enterDeb (
		.clk       (clk),
		.arstN     (arstN),
		.rawButton (Enter),
		.press     (enterPress)
	);

	buttonDebouncer undoDeb (
		.clk       (clk),
		.arstN     (arstN),
		.rawButton (Undo),
		.press     (undoPress)
	);

	////////////////////////////////////////////////////////////
	// Calculator core
	////////////////////////////////////////////////////////////

	calcSequencer seq0 (
		.clk        (clk),
		.arstN      (arstN),
		.enterPress (enterPress),
		.undoPress  (undoPress),
		.dataIn     (DataIn),
		.aluReq     (aluReq),
		.aluRes     (aluRes),
		.dispValue  (dispValue),
		.state      (Status),
		.flags      (Flags)
	);

	rpnAlu alu0 (
		.req (aluReq),
		.res (aluRes)
	);

	// Display path
	binToBcd conv0 (
		.clk      (clk),
		.arstN    (arstN),
		.inValid  (convValid),
		.inReady  (convReady),
		.inValue  (convValue),
		.outValid (bcdValid),
		.bcd      (bcd)
	);

	displayScanner scan0 (
		.clk       (clk),
		.arstN     (arstN),
		.value     (dispValue),
		.decimal   (DisplayFormat),
		.convValid (convValid),
		.convReady (convReady),
		.convValue (convValue),
		.bcdValid  (bcdValid),
		.bcd       (bcd),
		.segments  (Segments),
		.anodes    (Anodes)
	);

endmodule

`default_nettype wire

// File: logic/displayScanner.sv
`default_nettype none

`include "rpnCalc_cfg.svh"

module displayScanner (
	input  logic                       clk,
	input  logic                       arstN,
	input  logic [`RPN_DATA_WIDTH-1:0] value,
	input  logic                       decimal,
	output logic                       convValid,
	input  logic                       convReady,
	output logic [`RPN_DATA_WIDTH-1:0] convValue,
	input  logic                       bcdValid,
	input  rpnCalcPkg::bcdWord_t       bcd,
	output logic [6:0]                 segments,
	output logic [7:0]                 anodes
);

	import rpnCalcPkg::*;

	localparam int ScanCycles = `RPN_SCAN_CYCLES;
	localparam int PreW       = ($clog2(ScanCycles) > 0) ? $clog2(ScanCycles) : 1;
	localparam int HexDigits  = `RPN_DATA_WIDTH / 4;

	logic [PreW-1:0] prescale;
	logic [2:0]      digitIdx;
	logic            lastTick;    // Final cycle of the current digit
	logic            frameStart;  // Wrap from digit 7 to digit 0
	bcdWord_t        bcdLatch;    // Last finished conversion
	logic [3:0]      digitVal;
	logic [6:0]      segOn;       // Active high with a in bit 0

	////////////////////////////////////////////////////////////
	// Scan timing
	////////////////////////////////////////////////////////////

	assign lastTick   = (prescale == PreW'(ScanCycles - 1));
	assign frameStart = lastTick && (digitIdx == 3'd7);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			prescale <= '0;
			digitIdx <= '0;
		end else if (lastTick) begin
			prescale <= '0;
			digitIdx <= digitIdx + 1'b1;  // Wraps 7 to 0
		end else begin
			prescale <= prescale + 1'b1;
		end
	end

	// Conversion request held steady until taken
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			convValid <= 1'b0;
			convValue <= '0;
		end else if (convValid && convReady) begin
			convValid <= 1'b0;
		end else if (frameStart && !convValid) begin
			convValid <= 1'b1;
			convValue <= value;
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			bcdLatch <= '0;
		else if (bcdValid)
			bcdLatch <= bcd;
	end

	////////////////////////////////////////////////////////////
	// Digit select and segment encode
	////////////////////////////////////////////////////////////

	always_comb begin
		digitVal = 4'd0;  // Positions above the value
		if (decimal) begin
			case (digitIdx)
				3'd0: digitVal = bcdLatch.d0;
				3'd1: digitVal = bcdLatch.d1;
				3'd2: digitVal = bcdLatch.d2;
				3'd3: digitVal = bcdLatch.d3;
				3'd4: digitVal = bcdLatch.d4;
				default: digitVal = 4'd0;
			endcase
		end else if (int'(digitIdx) < HexDigits) begin
			digitVal = value[digitIdx*4 +: 4];
		end
	end

	always_comb begin
		case (digitVal)  // gfedcba
			4'h0: segOn = 7'h3F;
			4'h1: segOn = 7'h06;
			4'h2: segOn = 7'h5B;
			4'h3: segOn = 7'h4F;
			4'h4: segOn = 7'h66;
			4'h5: segOn = 7'h6D;
			4'h6: segOn = 7'h7D;
			4'h7: segOn = 7'h07;
			4'h8: segOn = 7'h7F;
			4'h9: segOn = 7'h6F;
			4'hA: segOn = 7'h77;
			4'hB: segOn = 7'h7C;
			4'hC: segOn = 7'h39;
			4'hD: segOn = 7'h5E;
			4'hE: segOn = 7'h79;
			default: segOn = 7'h71;  // F
		endcase
	end

	// Registered outputs go dark in reset
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			anodes   <= '1;
			segments <= '1;
		end else begin
			anodes   <= ~(8'b1 << digitIdx);  // Active low
			segments <= ~segOn;
		end
	end

endmodule

`default_nettype wire

// File: logic/binToBcd.sv
`default_nettype none

`include "rpnCalc_cfg.svh"

module binToBcd (
	input  logic                       clk,
	input  logic                       arstN,
	input  logic                       inValid,
	output logic                       inReady,
	input  logic [`RPN_DATA_WIDTH-1:0] inValue,
	output logic                       outValid,
	output rpnCalcPkg::bcdWord_t       bcd
);

	import rpnCalcPkg::*;

	localparam int W     = `RPN_DATA_WIDTH;
	localparam int StepW = $clog2(W + 1);
	localparam int BusyCycles = W + 2;  // Load, W shifts, result cycle

	logic             busy;
	logic [StepW-1:0] step;      // Shift steps done
	logic [W-1:0]     shiftBin;  // Binary bits still to shift in
	logic [19:0]      bcdWork;   // Five digits being built
	logic [19:0]      bcdAdj;    // Digits after the add-three pass

	// Add three to any digit of five or more before the shift
	always_comb begin
		for (int i = 0; i < 5; i++) begin
			if (bcdWork[i*4 +: 4] >= 4'd5)
				bcdAdj[i*4 +: 4] = bcdWork[i*4 +: 4] + 4'd3;
			else
				bcdAdj[i*4 +: 4] = bcdWork[i*4 +: 4];
		end
	end

	////////////////////////////////////////////////////////////
	// Conversion sequencing
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			busy     <= 1'b0;
			step     <= '0;
			outValid <= 1'b0;
		end else if (!busy) begin
			if (inValid) begin  // Transfer
				busy <= 1'b1;
				step <= '0;
			end
		end else if (step != StepW'(W)) begin
			step <= step + 1'b1;
		end else if (!outValid) begin
			outValid <= 1'b1;  // Digits ready
		end else begin
			outValid <= 1'b0;
			busy     <= 1'b0;  // Ready again next cycle
		end
	end

	// Datapath
	always_ff @(posedge clk) begin
		if (!busy && inValid) begin
			shiftBin <= inValue;
			bcdWork  <= '0;
		end else if (busy && step != StepW'(W)) begin
			bcdWork  <= {bcdAdj[18:0], shiftBin[W-1]};
			shiftBin <= shiftBin << 1;
		end
	end

	assign inReady = ~busy;
	assign bcd     = bcdWord_t'(bcdWork);

	// No new value is taken while a conversion runs
	readyLowWhileBusy: assert property (
		@(posedge clk) disable iff (!arstN)
		(inValid && inReady) |=> !inReady [*BusyCycles]
	) else $error("converter accepted input during a conversion");

endmodule

`default_nettype wire

// File: logic/rpnAlu.sv
`default_nettype none

`include "rpnCalc_cfg.svh"

module rpnAlu (
	input  rpnCalcPkg::aluReq_t req,
	output rpnCalcPkg::aluRes_t res
);

	import rpnCalcPkg::*;

	localparam int W = `RPN_DATA_WIDTH;

	logic [W:0] sum;   // Extra bit holds carry out
	logic [W:0] diff;  // Extra bit holds borrow
	logic       signA;
	logic       signB;

	assign signA = req.a[W-1];
	assign signB = req.b[W-1];

	always_comb begin
		sum  = {1'b0, req.a} + {1'b0, req.b};
		diff = {1'b0, req.a} - {1'b0, req.b};
		res  = '0;

		case (req.op)
			opAdd: begin
				res.value          = sum[W-1:0];
				res.flags.carry    = sum[W];
				// Same-sign inputs, result sign flipped
				res.flags.overflow = (signA == signB) && (sum[W-1] != signA);
			end
			opSub: begin
				res.value          = diff[W-1:0];
				res.flags.carry    = diff[W];  // Borrow
				// Opposite-sign inputs, result sign differs from a
				res.flags.overflow = (signA != signB) && (diff[W-1] != signA);
			end
			opAnd: res.value = req.a & req.b;
			default: res.value = req.a | req.b;  // opOr
		endcase

		res.flags.negative = res.value[W-1];
		res.flags.zero     = (res.value == '0);
	end

endmodule

`default_nettype wire

// File: logic/calcSequencer.sv
`default_nettype none

`include "rpnCalc_cfg.svh"

module calcSequencer (
	input  logic                       clk,
	input  logic                       arstN,
	input  logic                       enterPress,
	input  logic                       undoPress,
	input  logic [`RPN_DATA_WIDTH-1:0] dataIn,
	output rpnCalcPkg::aluReq_t        aluReq,
	input  rpnCalcPkg::aluRes_t        aluRes,
	output logic [`RPN_DATA_WIDTH-1:0] dispValue,
	output rpnCalcPkg::calcState_e     state,
	output rpnCalcPkg::aluFlags_t      flags
);

	import rpnCalcPkg::*;

	logic [`RPN_DATA_WIDTH-1:0] aReg;       // Operand A
	logic [`RPN_DATA_WIDTH-1:0] bReg;       // Operand B
	aluOp_e                     opReg;      // Stored opcode
	logic [`RPN_DATA_WIDTH-1:0] resultReg;  // Latched ALU value

	////////////////////////////////////////////////////////////
	// Entry FSM with result and flag latch
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state     <= stEnterA;
			flags     <= '0;
			resultReg <= '0;
		end else if (enterPress) begin  // Enter has priority over Undo
			case (state)
				stEnterA:  state <= stEnterB;
				stEnterB:  state <= stEnterOp;
				stEnterOp: begin
					state     <= stShowResult;
					resultReg <= aluRes.value;
					flags     <= aluRes.flags;
				end
				default: begin  // Back to a fresh calculation
					state <= stEnterA;
					flags <= '0;
				end
			endcase
		end else if (undoPress) begin
			flags <= '0;
			case (state)
				stShowResult: state <= stEnterOp;
				stEnterOp:    state <= stEnterB;
				stEnterB:     state <= stEnterA;
				default:      state <= stEnterA;  // Nothing before A
			endcase
		end
	end

	// Operand capture
	always_ff @(posedge clk) begin
		if (enterPress) begin
			case (state)
				stEnterA:  aReg  <= dataIn;
				stEnterB:  bReg  <= dataIn;
				stEnterOp: opReg <= aluOp_e'(dataIn[1:0]);
				default:   ;
			endcase
		end
	end

	// While the opcode is on the switches the ALU sees it live
	always_comb begin
		aluReq.a  = aReg;
		aluReq.b  = bReg;
		aluReq.op = (state == stEnterOp) ? aluOp_e'(dataIn[1:0]) : opReg;
	end

	assign dispValue = (state == stShowResult) ? resultReg : dataIn;

	stateLegal: assert property (
		@(posedge clk) disable iff (!arstN)
		!$isunknown(state) && (state inside {stEnterA, stEnterB, stEnterOp, stShowResult})
	) else $error("sequencer state is not a legal value");

endmodule

`default_nettype wire

// File: logic/buttonDebouncer.sv
`default_nettype none

`include "rpnCalc_cfg.svh"

module buttonDebouncer (
	input  logic clk,
	input  logic arstN,
	input  logic rawButton,
	output logic press
);

	localparam int DebCycles = `RPN_DEBOUNCE_CYCLES;
	localparam int CntW      = $clog2(DebCycles);

	logic [1:0]      syncQ;    // Two-flop synchroniser
	logic [CntW-1:0] cnt;      // Consecutive cycles away from the stable level
	logic            stable;   // Accepted button level
	logic            stableQ;  // Previous accepted level, for edge detect

	////////////////////////////////////////////////////////////
	// Synchroniser and stability counter
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			syncQ  <= '0;
			cnt    <= '0;
			stable <= 1'b0;
		end else begin
			syncQ <= {syncQ[0], rawButton};
			if (syncQ[1] != stable) begin
				if (cnt == CntW'(DebCycles - 1)) begin  // Held long enough
					stable <= syncQ[1];
					cnt    <= '0;
				end else begin
					cnt <= cnt + 1'b1;
				end
			end else begin
				cnt <= '0;  // Glitch ended, start over
			end
		end
	end

	// One pulse on each accepted rising level, none on release
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			stableQ <= 1'b0;
			press   <= 1'b0;
		end else begin
			stableQ <= stable;
			press   <= stable & ~stableQ;
		end
	end

	// A press is a single cycle wide
	pressSingleCycle: assert property (
		@(posedge clk) disable iff (!arstN) press |=> !press
	) else $error("press held for more than one cycle");

endmodule

`default_nettype wire

// File: logic/rpnCalcPkg.sv
`default_nettype none

`include "rpnCalc_cfg.svh"

package rpnCalcPkg;

	////////////////////////////////////////////////////////////
	// Sequencer states and ALU opcodes
	////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		stEnterA,      // Waiting for operand A
		stEnterB,      // Waiting for operand B
		stEnterOp,     // Waiting for opcode
		stShowResult   // Result latched and shown
	} calcState_e;

	typedef enum logic [1:0] {
		opAdd,
		opSub,
		opAnd,
		opOr
	} aluOp_e;

	////////////////////////////////////////////////////////////
	// Bundles between blocks
	////////////////////////////////////////////////////////////

	typedef struct packed {
		logic negative;  // Result MSB
		logic zero;
		logic carry;     // Carry out, or borrow on subtract
		logic overflow;  // Signed overflow
	} aluFlags_t;

	typedef struct packed {
		logic [`RPN_DATA_WIDTH-1:0] a;
		logic [`RPN_DATA_WIDTH-1:0] b;
		aluOp_e                     op;
	} aluReq_t;

	typedef struct packed {
		logic [`RPN_DATA_WIDTH-1:0] value;
		aluFlags_t                  flags;
	} aluRes_t;

	// Five decimal digits, d4 most significant
	typedef struct packed {
		logic [3:0] d4;
		logic [3:0] d3;
		logic [3:0] d2;
		logic [3:0] d1;
		logic [3:0] d0;
	} bcdWord_t;

endpackage

`default_nettype wire

// File: logic/rpnCalc_cfg.svh
`ifndef RPN_CALC_CFG_SVH
`define RPN_CALC_CFG_SVH

// Operand and result width in bits
`define RPN_DATA_WIDTH 16

// Cycles a synchronised button level must hold before it counts
// Short here for simulation, at least 2
`define RPN_DEBOUNCE_CYCLES 16

// Cycles each display digit stays lit, at least 1
`define RPN_SCAN_CYCLES 4

`endif
